// File: files.f
+incdir+bench
verilog/audio_fe_pkg.sv
verilog/axi_lite_regs.sv
verilog/test_pattern_gen.sv
verilog/coef_ram_arbiter.sv
verilog/fir_filter.sv
verilog/audio_front_end.sv
bench/tb_audio_front_end.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_audio_front_end -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1

grep -qxF ">>> PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: bench/axi_master_tasks.svh
`ifndef AXI_MASTER_TASKS_SVH
`define AXI_MASTER_TASKS_SVH

localparam int AXI_TIMEOUT = 64;    // clocks allowed per handshake

//////////////////////////////
// axi4-lite master
//////////////////////////////

// aw and w offered on the same edge
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.bready  <= 1'b1;
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
        if (waited > AXI_TIMEOUT)
            stop_with_error("timeout waiting for awready and wready");
    end while (!(axil_rsp.awready && axil_rsp.wready));
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
        if (waited > AXI_TIMEOUT)
            stop_with_error("timeout waiting for bvalid");
    end while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;          // taken on this edge, bready already high
    axil_req.bready <= 1'b0;
endtask

// single beat read
task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int waited;
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.rready  <= 1'b1;
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
        if (waited > AXI_TIMEOUT)
            stop_with_error("timeout waiting for arready");
    end while (!axil_rsp.arready);
    axil_req.arvalid <= 1'b0;
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
        if (waited > AXI_TIMEOUT)
            stop_with_error("timeout waiting for rvalid");
    end while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready <= 1'b0;
endtask

`endif

// File: bench/tb_audio_front_end.sv
module tb_audio_front_end;
    import audio_fe_pkg::*;

    localparam int          SMP_DIV    = 15;
    localparam int          NUM_TAPS   = 8;
    localparam int          TAP_COUNT  = 3;
    localparam int          IMP_PERIOD = TAP_COUNT + 4;   // samples per impulse
    localparam logic [7:0]  TRI_INC    = 8'hC3;
    localparam logic [23:0] TRI_STEP   = 24'(TRI_INC) << 13;
    localparam int          PH_NONE    = 0;
    localparam int          PH_DC      = 1;
    localparam int          PH_PCM     = 2;
    localparam int          PH_TRI     = 3;
    localparam int          PH_IMP     = 4;

    logic               clk = 1'b0;
    logic               rst_n = 1'b0;
    axil_req_t          axil_req = '0;
    axil_rsp_t          axil_rsp;
    logic               pcm_valid = 1'b0;
    stereo_t            pcm_data = '0;
    logic               out_valid;
    stereo_t            out_data;

    int                 seed = 18753;
    int                 errors = 0;
    int                 phase = PH_NONE;    // which checks are armed
    logic               rst_chk = 1'b1;
    logic [23:0]        dc_exp = '0;
    logic signed [15:0] coefs [NUM_TAPS];
    int                 n_out = 0;          // outputs seen in this phase
    int                 gap = 0;            // clocks since last out_valid
    logic [23:0]        tri_exp = '0;
    logic [23:0]        tri_prev = '0;
    logic               tri_up = 1'b1;
    stereo_t            pcm_last = '0;

    always #4 clk = ~clk;

    audio_front_end #(
        .SMP_DIV  (SMP_DIV),
        .NUM_TAPS (NUM_TAPS)
    ) audio_front_end_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .pcm_valid (pcm_valid),
        .pcm_data  (pcm_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    //////////////////////////////
    // failure reporting
    //////////////////////////////
    task automatic stop_on_mismatch(input string name, input logic [63:0] exp,
                                    input logic [63:0] act);
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_with_error(input string what);
        errors++;
        $display("ERROR: %s", what);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_equal(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (exp == act)
            else stop_on_mismatch(name, exp, act);
    endtask

    `include "axi_master_tasks.svh"

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic ctrl_t make_ctrl(input logic run, input logic bypass,
                                        input pattern_e pat, input logic [3:0] taps);
        ctrl_t c;
        c            = '0;
        c.run        = run;
        c.fir_bypass = bypass;
        c.pattern    = pat;
        c.tap_count  = taps;
        c.tri_inc    = TRI_INC;
        return c;
    endfunction

    // {up, value} of the sample after cur
    function automatic logic [24:0] tri_next(input logic [23:0] cur, input logic up);
        if (up && cur + TRI_STEP >= 24'h7FFFFE)
            return {1'b0, cur - TRI_STEP};      // top limit, fold down
        if (!up && cur - TRI_STEP <= TRI_STEP)
            return {1'b1, cur + TRI_STEP};      // floor, back up
        return up ? {1'b1, cur + TRI_STEP} : {1'b0, cur - TRI_STEP};
    endfunction

    // impulse at sample 1 of each period walks through the taps
    function automatic logic [23:0] imp_expect(input int idx);
        int     k;
        longint p;
        k = idx % IMP_PERIOD - 1;
        if (k < 0 || k > TAP_COUNT)
            return '0;
        p = (longint'(coefs[k]) * 64'sh7FFF00) >>> 15;
        if (p > 64'sd8388607)
            p = 64'sd8388607;
        else if (p < -64'sd8388608)
            p = -64'sd8388608;
        return p[23:0];
    endfunction

    always @(posedge clk) begin
        gap <= out_valid ? 1 : gap + 1;
        if (pcm_valid)
            pcm_last <= pcm_data;
        if (phase == PH_NONE) begin
            n_out   <= 0;
            tri_exp <= '0;                      // generator restarts from zero
            tri_up  <= 1'b1;
        end else if (out_valid) begin
            n_out             <= n_out + 1;
            tri_prev          <= out_data.l;
            {tri_up, tri_exp} <= tri_next(tri_exp, tri_up);
        end
    end

    //////////////////////////////
    // output checks
    //////////////////////////////
    assert property (@(posedge clk) rst_chk |-> !out_valid && !axil_rsp.awready
        && !axil_rsp.wready && !axil_rsp.bvalid && !axil_rsp.arready && !axil_rsp.rvalid)
        else stop_with_error("a valid or ready output was high during or after reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_DC && out_valid |-> out_data == {dc_exp, dc_exp})
        else stop_on_mismatch("dc level", {$sampled(dc_exp), $sampled(dc_exp)},
                              $sampled(out_data));
    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_DC && out_valid && n_out > 0 |-> gap == SMP_DIV + 1)
        else stop_on_mismatch("dc strobe spacing", SMP_DIV + 1, $sampled(gap));

    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_PCM && pcm_valid |=> out_valid)
        else stop_with_error("no out_valid one clock after pcm_valid");
    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_PCM && out_valid |-> out_data == pcm_last)
        else stop_on_mismatch("pcm bypass", $sampled(pcm_last), $sampled(out_data));

    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_TRI && out_valid |-> out_data == {tri_exp, tri_exp})
        else stop_on_mismatch("triangle value", {$sampled(tri_exp), $sampled(tri_exp)},
                              $sampled(out_data));
    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_TRI && out_valid && n_out > 0 |->
        24'(out_data.l - tri_prev) == TRI_STEP || 24'(tri_prev - out_data.l) == TRI_STEP)
        else stop_on_mismatch("triangle step", TRI_STEP,
                              24'($sampled(out_data.l) - $sampled(tri_prev)));
    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_TRI && out_valid |-> $unsigned(out_data.l) <= 24'h7FFFFE)
        else stop_with_error("triangle output outside 0 to 0x7ffffe");

    // first period still carries history from earlier phases
    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_IMP && out_valid && n_out >= IMP_PERIOD |->
        out_data == {imp_expect(n_out), imp_expect(n_out)})
        else stop_on_mismatch("impulse response",
                              {imp_expect($sampled(n_out)), imp_expect($sampled(n_out))},
                              $sampled(out_data));
    assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_IMP && out_valid |-> $past(audio_front_end_inst.gen_valid, TAP_COUNT + 3))
        else stop_with_error("filter output not tap_count+3 clocks after gen_valid");

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic wait_outputs(input int count);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count) begin
            @(posedge clk);
            cycles++;
            if (out_valid)
                seen++;
            if (cycles > (count + 2) * (SMP_DIV + 1) + 64)
                stop_with_error("timeout waiting for out_valid strobes");
        end
    endtask

    // stop, drain, arm the checks, then run the new mode
    task automatic start_phase(input int ph, input ctrl_t c);
        ctrl_t      idle_c;
        logic [1:0] resp;
        idle_c     = c;
        idle_c.run = 1'b0;
        phase <= PH_NONE;
        axil_write(CTRL_ADDR, 32'(idle_c), resp);
        expect_equal("ctrl stop resp", RESP_OKAY, resp);
        repeat (24) @(posedge clk);         // samples in flight finish
        phase <= ph;
        axil_write(CTRL_ADDR, 32'(c), resp);
        expect_equal("ctrl start resp", RESP_OKAY, resp);
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] rd;
        logic [1:0]  resp;
        sample_t     pl;
        sample_t     pr;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        rst_chk <= 1'b0;
        axil_read(CTRL_ADDR, rd, resp);
        expect_equal("ctrl after reset", 32'h0, rd);
        expect_equal("ctrl read resp after reset", RESP_OKAY, resp);

        // register access, run kept off
        word = 32'($random(seed)) & 32'hFFFF_FFFE;
        axil_write(CTRL_ADDR, word, resp);
        expect_equal("ctrl write resp", RESP_OKAY, resp);
        axil_read(CTRL_ADDR, rd, resp);
        expect_equal("ctrl readback", word, rd);
        expect_equal("ctrl read resp", RESP_OKAY, resp);
        for (int i = 0; i < NUM_TAPS; i++) begin
            coefs[i] = 16'($random(seed));
            axil_write(COEF_BASE + 8'(4 * i), {16'h0, coefs[i]}, resp);
            expect_equal("coef write resp", RESP_OKAY, resp);
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            axil_read(COEF_BASE + 8'(4 * i), rd, resp);
            expect_equal("coef readback", {16'h0, coefs[i]}, rd);
            expect_equal("coef read resp", RESP_OKAY, resp);
        end
        axil_write(8'h10, 32'h1234_5678, resp);
        expect_equal("unmapped write resp", RESP_SLVERR, resp);
        axil_read(8'h44, rd, resp);
        expect_equal("unmapped read resp", RESP_SLVERR, resp);

        // dc levels, modes 1 to 4
        for (int i = 1; i <= 4; i++) begin
            case (i)
                1:       dc_exp <= 24'h000100;
                2:       dc_exp <= 24'hFFFF00;
                3:       dc_exp <= 24'h7FFF00;
                default: dc_exp <= 24'h800100;
            endcase
            start_phase(PH_DC, make_ctrl(1'b1, 1'b1, pattern_e'(i), 4'd0));
            wait_outputs(4);
        end

        // live pcm straight through
        start_phase(PH_PCM, make_ctrl(1'b0, 1'b1, pcm_bypass, 4'd0));
        for (int i = 0; i < 20; i++) begin
            pl = 24'($random(seed));
            pr = 24'($random(seed));
            if (pr == pl)
                pr = ~pl;
            @(posedge clk);
            pcm_valid <= 1'b1;
            pcm_data  <= '{l: pl, r: pr};
            @(posedge clk);
            pcm_valid <= 1'b0;
            repeat (2) @(posedge clk);
        end

        start_phase(PH_TRI, make_ctrl(1'b1, 1'b1, triangle, 4'd0));
        wait_outputs(30);                   // several reversals

        start_phase(PH_IMP, make_ctrl(1'b1, 1'b0, impulse, 4'(TAP_COUNT)));
        wait_outputs(3 * IMP_PERIOD);
        phase <= PH_NONE;
        axil_write(CTRL_ADDR, 32'h0, resp);

        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/audio_front_end.sv
module audio_front_end #(
    parameter int SMP_DIV  = 63,
    parameter int NUM_TAPS = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  audio_fe_pkg::axil_req_t axil_req,
    output audio_fe_pkg::axil_rsp_t axil_rsp,
    input  logic                    pcm_valid,
    input  audio_fe_pkg::stereo_t   pcm_data,
    output logic                    out_valid,
    output audio_fe_pkg::stereo_t   out_data
);
    import audio_fe_pkg::*;

    ctrl_t       ctrl;          // shared control register
    coef_req_t   cpu_req;
    coef_req_t   fir_req;
    logic        cpu_gnt;
    logic [15:0] cpu_rdata;
    logic [15:0] fir_rdata;
    logic        gen_valid;
    stereo_t     gen_data;

    //////////////////////////////
    // cpu side
    //////////////////////////////
    axi_lite_regs axi_lite_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .ctrl       (ctrl),
        .coef_req   (cpu_req),
        .coef_gnt   (cpu_gnt),
        .coef_rdata (cpu_rdata)
    );

    coef_ram_arbiter #(
        .NUM_TAPS (NUM_TAPS)
    ) coef_ram_arbiter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_gnt   (cpu_gnt),
        .cpu_rdata (cpu_rdata),
        .fir_req   (fir_req),
        .fir_rdata (fir_rdata)
    );

    //////////////////////////////
    // sample path
    //////////////////////////////
    test_pattern_gen #(
        .SMP_DIV (SMP_DIV)
    ) test_pattern_gen_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .pcm_valid (pcm_valid),
        .pcm_data  (pcm_data),
        .gen_valid (gen_valid),
        .gen_data  (gen_data)
    );

    fir_filter #(
        .NUM_TAPS (NUM_TAPS)
    ) fir_filter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .gen_valid  (gen_valid),
        .gen_data   (gen_data),
        .coef_req   (fir_req),
        .coef_rdata (fir_rdata),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// File: verilog/fir_filter.sv
module fir_filter #(
    parameter int NUM_TAPS = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  audio_fe_pkg::ctrl_t     ctrl,
    input  logic                    gen_valid,
    input  audio_fe_pkg::stereo_t   gen_data,
    output audio_fe_pkg::coef_req_t coef_req,
    input  logic signed [15:0]      coef_rdata,
    output logic                    out_valid,
    output audio_fe_pkg::stereo_t   out_data
);
    import audio_fe_pkg::*;

    localparam int AW    = $clog2(NUM_TAPS);
    localparam int ACC_W = 41 + AW;            // 24x16 product plus tap growth

    typedef enum logic [1:0] {
        st_idle,
        st_load,        // coef 0 requested
        st_mac          // one tap per clock
    } state_e;

    state_e                  state;
    stereo_t                 hist [NUM_TAPS];   // newest at 0
    logic [3:0]              cnt;               // tap whose coef is on rdata
    logic [3:0]              last_q;            // final tap of this pass
    logic signed [ACC_W-1:0] acc_l;
    logic signed [ACC_W-1:0] acc_r;
    logic signed [ACC_W-1:0] sum_l;
    logic signed [ACC_W-1:0] sum_r;
    stereo_t                 tap;
    logic                    last_mac;

    // drop q15 scaling, clip to 24 bits
    function automatic sample_t sat_q15(input logic signed [ACC_W-1:0] v);
        logic signed [ACC_W-1:0] s;
        s = v >>> 15;
        if (&s[ACC_W-1:23] || ~|s[ACC_W-1:23])
            return s[23:0];
        return s[ACC_W-1] ? 24'h800000 : 24'h7FFFFF;
    endfunction

    assign tap      = hist[cnt[AW-1:0]];
    assign sum_l    = acc_l + tap.l * coef_rdata;
    assign sum_r    = acc_r + tap.r * coef_rdata;
    assign last_mac = (state == st_mac) && (cnt == last_q);

    // read only, next coef fetched one clock ahead
    always_comb begin
        coef_req       = '0;
        coef_req.valid = (state == st_load) || ((state == st_mac) && !last_mac);
        coef_req.addr  = (state == st_load) ? 3'd0 : 3'(cnt + 4'd1);
    end

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            cnt       <= '0;
            last_q    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (gen_valid && ctrl.fir_bypass) begin
                        out_valid <= 1'b1;
                    end else if (gen_valid) begin
                        // never run past the history depth
                        last_q <= (ctrl.tap_count > 4'(NUM_TAPS - 1)) ?
                                  4'(NUM_TAPS - 1) : ctrl.tap_count;
                        state  <= st_load;
                    end
                end
                st_load: state <= st_mac;
                st_mac: begin
                    if (last_mac) begin
                        out_valid <= 1'b1;      // saturated word ready
                        state     <= st_idle;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    //////////////////////////////
    // datapath
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (gen_valid) begin
            hist[0] <= gen_data;
            for (int i = 1; i < NUM_TAPS; i++)
                hist[i] <= hist[i-1];
        end
        if (state == st_load) begin
            acc_l <= '0;
            acc_r <= '0;
        end else if (state == st_mac) begin
            acc_l <= sum_l;
            acc_r <= sum_r;
        end
        if (state == st_idle && gen_valid && ctrl.fir_bypass)
            out_data <= gen_data;
        else if (last_mac)
            out_data <= '{l: sat_q15(sum_l), r: sat_q15(sum_r)};
    end

    // sample period has to cover load, all taps and the output cycle
    assert property (@(posedge clk) disable iff (!rst_n) gen_valid |-> state == st_idle);

endmodule

// File: verilog/coef_ram_arbiter.sv
module coef_ram_arbiter #(
    parameter int NUM_TAPS = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  audio_fe_pkg::coef_req_t cpu_req,
    output logic                    cpu_gnt,
    output logic [15:0]             cpu_rdata,
    input  audio_fe_pkg::coef_req_t fir_req,
    output logic [15:0]             fir_rdata
);
    import audio_fe_pkg::*;

    localparam int AW = $clog2(NUM_TAPS);

    logic [15:0] mem [NUM_TAPS];    // q1.15 coefficients
    logic [15:0] rd_q;
    logic        fir_gnt;
    coef_req_t   sel;

    // filter has fixed priority, cpu fills the gaps
    assign fir_gnt = fir_req.valid;
    assign cpu_gnt = cpu_req.valid && !fir_req.valid;
    assign sel     = fir_gnt ? fir_req : cpu_req;

    // single port, registered read
    always_ff @(posedge clk) begin
        if (cpu_gnt && cpu_req.we)
            mem[cpu_req.addr[AW-1:0]] <= cpu_req.data;
        rd_q <= mem[sel.addr[AW-1:0]];
    end

    // one read register, owner is whoever was granted last cycle
    assign cpu_rdata = rd_q;
    assign fir_rdata = rd_q;

    // a stalled cpu request keeps its address until served
    assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.valid && !cpu_gnt |=> cpu_req.valid && $stable(cpu_req.addr));

endmodule

// File: verilog/test_pattern_gen.sv
module test_pattern_gen #(
    parameter int SMP_DIV = 63
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  audio_fe_pkg::ctrl_t   ctrl,
    input  logic                  pcm_valid,
    input  audio_fe_pkg::stereo_t pcm_data,
    output logic                  gen_valid,
    output audio_fe_pkg::stereo_t gen_data
);
    import audio_fe_pkg::*;

    localparam int CW = $clog2(SMP_DIV + 1);

    logic [CW-1:0] smp_cnt;
    logic          smp_stb;         // one clock every SMP_DIV+1
    logic          pat_valid;
    sample_t       pat_q;
    logic [23:0]   tri_q;
    logic [23:0]   tri_step;
    logic          tri_down;
    logic [4:0]    imp_cnt;

    assign tri_step = {3'h0, ctrl.tri_inc, 13'h0000};

    //////////////////////////////
    // sample strobe
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            smp_cnt   <= '0;
            smp_stb   <= 1'b0;
            pat_valid <= 1'b0;
        end else begin
            pat_valid <= smp_stb;                   // word lands one clock later
            if (!ctrl.run) begin
                smp_cnt <= '0;
                smp_stb <= 1'b0;
            end else if (smp_cnt == CW'(SMP_DIV)) begin
                smp_cnt <= '0;
                smp_stb <= 1'b1;
            end else begin
                smp_cnt <= smp_cnt + 1'b1;
                smp_stb <= 1'b0;
            end
        end
    end

    // triangle, stays in the positive half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tri_q    <= '0;
            tri_down <= 1'b0;
        end else if (!ctrl.run) begin
            tri_q    <= '0;
            tri_down <= 1'b0;
        end else if (smp_stb) begin
            if (!tri_down) begin
                if (tri_q + tri_step < 24'h7FFFFE) begin
                    tri_q <= tri_q + tri_step;
                end else begin
                    tri_q    <= tri_q - tri_step;  // top reached, fold down
                    tri_down <= 1'b1;
                end
            end else begin
                if (tri_q - tri_step > tri_step) begin
                    tri_q <= tri_q - tri_step;
                end else begin
                    tri_q    <= tri_q + tri_step;  // floor, head back up
                    tri_down <= 1'b0;
                end
            end
        end
    end

    // impulse period is tap_count+4 strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            imp_cnt <= '0;
        else if (!ctrl.run)
            imp_cnt <= '0;
        else if (smp_stb)
            imp_cnt <= (imp_cnt == {1'b0, ctrl.tap_count} + 5'd3) ? 5'd0 : imp_cnt + 5'd1;
    end

    //////////////////////////////
    // pattern mux
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (smp_stb) begin
            case (ctrl.pattern)
                dc_min_pos: pat_q <= 24'h000100;
                dc_min_neg: pat_q <= 24'hFFFF00;
                dc_max_pos: pat_q <= 24'h7FFF00;
                dc_max_neg: pat_q <= 24'h800100;
                triangle:   pat_q <= tri_q;
                impulse:    pat_q <= (imp_cnt == 5'd1) ? 24'h7FFF00 : 24'h000000;
                default:    pat_q <= '0;
            endcase
        end
    end

    // live pcm goes straight through, same cycle
    assign gen_valid = (ctrl.pattern == pcm_bypass) ? pcm_valid : pat_valid;
    assign gen_data  = (ctrl.pattern == pcm_bypass) ? pcm_data : stereo_t'{pat_q, pat_q};

endmodule

// File: verilog/axi_lite_regs.sv
module axi_lite_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  audio_fe_pkg::axil_req_t axil_req,
    output audio_fe_pkg::axil_rsp_t axil_rsp,
    output audio_fe_pkg::ctrl_t     ctrl,
    output audio_fe_pkg::coef_req_t coef_req,
    input  logic                    coef_gnt,
    input  logic [15:0]             coef_rdata
);
    import audio_fe_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_wgnt,        // coef write waiting on the arbiter
        st_bresp,
        st_rgnt,        // coef read waiting on the arbiter
        st_rdata,       // ram output valid this cycle
        st_rresp
    } state_e;

    state_e      state;
    logic [1:0]  bresp_q;
    logic [1:0]  rresp_q;
    logic [31:0] rdata_q;
    reg_word_u   wword;
    reg_word_u   rd_word;
    logic        wr_hs;
    logic        rd_hs;
    logic        wr_ctrl;
    logic        wr_coef;
    logic        rd_ctrl;
    logic        rd_coef;

    assign wword = axil_req.wdata;
    assign rd_word.coef = '{rsvd: '0, coef: coef_rdata};

    // aw and w taken together, write wins a tie with ar
    assign wr_hs = (state == st_idle) && axil_req.awvalid && axil_req.wvalid;
    assign rd_hs = (state == st_idle) && axil_req.arvalid && !wr_hs;

    // address decode, coef window is 0x20..0x3c word aligned
    assign wr_ctrl = axil_req.awaddr == CTRL_ADDR;
    assign wr_coef = (axil_req.awaddr & 8'hE3) == COEF_BASE;
    assign rd_ctrl = axil_req.araddr == CTRL_ADDR;
    assign rd_coef = (axil_req.araddr & 8'hE3) == COEF_BASE;

    //////////////////////////////
    // access fsm
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            ctrl     <= '0;         // run off, pcm bypass
            coef_req <= '0;
            bresp_q  <= RESP_OKAY;
            rresp_q  <= RESP_OKAY;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_hs) begin
                        if (wr_ctrl) begin
                            ctrl    <= wword.ctrl;
                            bresp_q <= RESP_OKAY;
                            state   <= st_bresp;
                        end else if (wr_coef) begin
                            coef_req <= '{valid: 1'b1, we: 1'b1,
                                          addr: axil_req.awaddr[4:2],
                                          data: wword.coef.coef};
                            state    <= st_wgnt;
                        end else begin
                            bresp_q <= RESP_SLVERR;     // unmapped
                            state   <= st_bresp;
                        end
                    end else if (rd_hs) begin
                        if (rd_coef) begin
                            coef_req <= '{valid: 1'b1, we: 1'b0,
                                          addr: axil_req.araddr[4:2], data: '0};
                            state    <= st_rgnt;
                        end else begin
                            rresp_q <= rd_ctrl ? RESP_OKAY : RESP_SLVERR;
                            state   <= st_rresp;
                        end
                    end
                end
                st_wgnt: begin
                    if (coef_gnt) begin          // ram written on this edge
                        coef_req.valid <= 1'b0;
                        bresp_q        <= RESP_OKAY;
                        state          <= st_bresp;
                    end
                end
                st_bresp: if (axil_req.bready) state <= st_idle;
                st_rgnt: begin
                    if (coef_gnt) begin
                        coef_req.valid <= 1'b0;
                        state          <= st_rdata;
                    end
                end
                st_rdata: begin
                    rresp_q <= RESP_OKAY;
                    state   <= st_rresp;
                end
                st_rresp: if (axil_req.rready) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // read data word
    always_ff @(posedge clk) begin
        if (rd_hs)
            rdata_q <= rd_ctrl ? 32'(ctrl) : 32'h0;
        else if (state == st_rdata)
            rdata_q <= rd_word;         // coef back from ram
    end

    always_comb begin
        axil_rsp.awready = wr_hs;
        axil_rsp.wready  = wr_hs;
        axil_rsp.bvalid  = state == st_bresp;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = rd_hs;
        axil_rsp.rvalid  = state == st_rresp;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    // responses hold until the master takes them
    assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));
    assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

// File: verilog/audio_fe_pkg.sv
package audio_fe_pkg;

    //////////////////////////////
    // audio words
    //////////////////////////////
    typedef logic signed [23:0] sample_t;      // one 24-bit pcm word

    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_t;

    // pattern select, 0 passes live pcm through
    typedef enum logic [2:0] {
        pcm_bypass = 3'd0,
        dc_min_pos = 3'd1,
        dc_min_neg = 3'd2,
        dc_max_pos = 3'd3,
        dc_max_neg = 3'd4,
        triangle   = 3'd5,
        impulse    = 3'd6
    } pattern_e;

    //////////////////////////////
    // register views
    //////////////////////////////
    typedef struct packed {
        logic [14:0] rsvd;
        logic [7:0]  tri_inc;                   // triangle step, lands at bit 13
        logic [3:0]  tap_count;                 // taps in use minus one
        pattern_e    pattern;
        logic        fir_bypass;
        logic        run;                       // bit 0
    } ctrl_t;

    typedef struct packed {
        logic [15:0]        rsvd;
        logic signed [15:0] coef;               // q1.15
    } coef_word_t;

    // one data word, meaning picked by the address
    typedef union packed {
        ctrl_t      ctrl;
        coef_word_t coef;
    } reg_word_u;

    typedef struct packed {
        logic               valid;
        logic               we;
        logic [2:0]         addr;
        logic signed [15:0] data;
    } coef_req_t;

    //////////////////////////////
    // axi4-lite channels
    //////////////////////////////
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [7:0] CTRL_ADDR   = 8'h00;
    localparam logic [7:0] COEF_BASE   = 8'h20; // 8 words up to 0x3c
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
